//--- include/tx_stream_defs.svh
/*
 * Widths, FIFO sizing and descriptor field positions of the transmit stream
 * builder. The FIFO depth must be a power of two.
 */
`ifndef TX_STREAM_DEFS_SVH
`define TX_STREAM_DEFS_SVH

// stream and payload widths
`define TXS_DATA_W            128
`define TXS_DW_W              32
`define TXS_LEN_W             10

// beat FIFO, almost full is raised this many entries before full
`define TXS_FIFO_DEPTH        64
`define TXS_FIFO_AFULL_GAP    8

// descriptor fields
`define TXS_DESC_HASDATA_BIT  126
`define TXS_DESC_4DW_BIT      125
`define TXS_DESC_LEN_LSB      96

// lowest address bit, 3dw headers carry it in bits 63:32
`define TXS_ADDR3_LSB         32
`define TXS_ADDR4_LSB         0

`endif

//--- source/tx_stream_pkg.sv
/*
 * Types shared by the transmit stream stages.
 * Field widths follow tx_stream_defs.svh.
 */
`include "tx_stream_defs.svh"

package tx_stream_pkg;

   // bit 1 selects the 4dw header, bit 0 marks a payload
   typedef enum logic [1:0] {
      fmt_3dw_nodata = 2'b00,
      fmt_3dw_data   = 2'b01,
      fmt_4dw_nodata = 2'b10,
      fmt_4dw_data   = 2'b11
   } hdr_fmt_e;

   typedef enum logic [1:0] {
      st_idle    = 2'd0,
      st_header  = 2'd1,
      st_payload = 2'd2
   } pack_state_e;

   // stream doubleword count, header plus pad plus payload
   typedef logic [`TXS_LEN_W:0] dw_cnt_t;

   typedef struct packed {
      hdr_fmt_e                fmt;
      logic [`TXS_LEN_W-1:0]   length;
      logic                    pad;
      logic [`TXS_DATA_W-1:0]  hdr;
      logic                    err;
      dw_cnt_t                 words;
   } tx_desc_t;

   // framing bits sit above the data, err on top
   typedef struct packed {
      logic                    err;
      logic                    sop;
      logic                    eop;
      logic                    empty;
      logic [`TXS_DATA_W-1:0]  data;
   } tx_beat_t;

endpackage

//--- source/tx_req_ctrl.sv
/*
 * Request side. tx_desc and tx_err must hold from the rise of tx_req until
 * tx_ack. Payload beats are expected from the cycle after the acknowledge.
 * A zero length field with payload is taken as zero doublewords.
 */
`include "tx_stream_defs.svh"

module tx_req_ctrl (
   input  logic                     clk_in,
   input  logic                     rstn,
   input  logic                     tx_req,
   input  logic [`TXS_DATA_W-1:0]   tx_desc,
   input  logic                     tx_err,
   input  logic                     tx_dv,
   input  logic                     almost_full,
   output logic                     tx_ack,
   output logic                     tx_ws,
   output tx_stream_pkg::tx_desc_t  desc,
   output logic                     desc_valid,
   output logic                     data_take
);

   logic                     req_d;
   logic                     req_rise;
   logic                     pending;
   logic                     is_4dw;
   logic                     has_data;
   logic                     addr_bit2;
   tx_stream_pkg::tx_desc_t  dec;

   assign req_rise = tx_req & ~req_d;

   // --------------------------------------------------------------------------
   // descriptor decode
   // --------------------------------------------------------------------------
   always_comb begin
      is_4dw     = tx_desc[`TXS_DESC_4DW_BIT];
      has_data   = tx_desc[`TXS_DESC_HASDATA_BIT];
      addr_bit2  = is_4dw ? tx_desc[`TXS_ADDR4_LSB+2] : tx_desc[`TXS_ADDR3_LSB+2];
      dec.fmt    = tx_stream_pkg::hdr_fmt_e'({is_4dw, has_data});
      dec.length = has_data ? tx_desc[`TXS_DESC_LEN_LSB +: `TXS_LEN_W] : '0;
      // pad keeps the first payload dword on a quadword boundary
      dec.pad    = has_data & (is_4dw ? addr_bit2 : ~addr_bit2);
      dec.hdr    = tx_desc;
      dec.err    = tx_err;
      dec.words  = (is_4dw ? tx_stream_pkg::dw_cnt_t'(4) : tx_stream_pkg::dw_cnt_t'(3))
                 + tx_stream_pkg::dw_cnt_t'(dec.pad)
                 + tx_stream_pkg::dw_cnt_t'(dec.length);
   end

   // --------------------------------------------------------------------------
   // request handshake and wait state
   // --------------------------------------------------------------------------
   always_ff @(posedge clk_in) begin
      if (!rstn) begin
         req_d   <= 1'b0;
         pending <= 1'b0;
         tx_ws   <= 1'b0;
      end else begin
         req_d <= tx_req;
         tx_ws <= almost_full;
         if (tx_ack) begin
            pending <= 1'b0;
         end else if (req_rise) begin
            pending <= 1'b1;
         end
      end
   end

   // one decode per request, captured on the request edge
   always_ff @(posedge clk_in) begin
      if (req_rise) begin
         desc <= dec;
      end
   end

   // ack waits out any wait state, so its latency varies
   assign tx_ack     = pending & ~tx_ws;
   assign desc_valid = tx_ack;
   assign data_take  = tx_dv & ~tx_ws;

endmodule

//--- source/tx_beat_packer.sv
/*
 * Lays header, pad and payload dwords onto 128-bit beats. Beats leave two
 * cycles after the ack or the take that completes them. The next request
 * must not be acknowledged before the last payload take of the previous one.
 */
`include "tx_stream_defs.svh"

module tx_beat_packer (
   input  logic                     clk_in,
   input  logic                     rstn,
   input  tx_stream_pkg::tx_desc_t  desc,
   input  logic                     desc_valid,
   input  logic                     data_take,
   input  logic [`TXS_DATA_W-1:0]   tx_data,
   output logic                     push,
   output tx_stream_pkg::tx_beat_t  beat
);

   tx_stream_pkg::pack_state_e  state;
   tx_stream_pkg::pack_state_e  state_nx;
   tx_stream_pkg::tx_desc_t     desc_r;
   tx_stream_pkg::dw_cnt_t      rem;
   tx_stream_pkg::dw_cnt_t      cur_rem;
   tx_stream_pkg::tx_beat_t     beat_nx;
   logic [`TXS_DATA_W-1:0]      cur_r;
   logic [`TXS_DATA_W-1:0]      prev_r;
   logic [`TXS_DATA_W-1:0]      hdr_seed;
   logic [2:0]                  lead_dw;
   logic [1:0]                  shift_dw;
   logic                        hdr_go;
   logic                        take_r;
   logic                        is_4dw;
   logic                        has_data;
   logic                        wait_d0;
   logic                        fire;
   logic                        eop;

   // stream lane l comes from lane (4 - sh + l) of {cur, prev}, unused lanes zero
   function automatic logic [`TXS_DATA_W-1:0] realign(
      input logic [`TXS_DATA_W-1:0]  prev,
      input logic [`TXS_DATA_W-1:0]  cur,
      input logic [1:0]              sh,
      input tx_stream_pkg::dw_cnt_t  left
   );
      logic [2*`TXS_DATA_W-1:0]  both;
      logic [`TXS_DATA_W-1:0]    res;
      int                        src;
      both = {cur, prev};
      res  = '0;
      for (int lane = 0; lane < 4; lane++) begin
         src = 4 - int'(sh) + lane;
         if (lane < left) begin
            res[`TXS_DATA_W-`TXS_DW_W*(lane+1) +: `TXS_DW_W] =
               both[`TXS_DW_W*src +: `TXS_DW_W];
         end
      end
      return res;
   endfunction

   // a 3dw header sits in input lanes 1..3 of prev so that D0 lands behind it
   assign hdr_seed = (desc.fmt[1] == 1'b0) ?
                     {desc.hdr[63:32], desc.hdr[95:64], desc.hdr[127:96], 32'h0} : '0;

   // --------------------------------------------------------------------------
   // stage 1: capture descriptor and input beats
   // --------------------------------------------------------------------------
   always_ff @(posedge clk_in) begin
      if (!rstn) begin
         hdr_go <= 1'b0;
         take_r <= 1'b0;
      end else begin
         hdr_go <= desc_valid;
         take_r <= data_take;
      end
   end

   always_ff @(posedge clk_in) begin
      if (data_take) begin
         cur_r <= tx_data;
      end
      if (desc_valid) begin
         desc_r <= desc;
         prev_r <= hdr_seed;
      end else if (take_r) begin
         prev_r <= cur_r;
      end
   end

   // --------------------------------------------------------------------------
   // stage 2: form the beat
   // --------------------------------------------------------------------------
   always_comb begin
      is_4dw   = (desc_r.fmt == tx_stream_pkg::fmt_4dw_data) ||
                 (desc_r.fmt == tx_stream_pkg::fmt_4dw_nodata);
      has_data = (desc_r.fmt == tx_stream_pkg::fmt_3dw_data) ||
                 (desc_r.fmt == tx_stream_pkg::fmt_4dw_data);
      lead_dw  = (is_4dw ? 3'd4 : 3'd3) + {2'b00, desc_r.pad};
      shift_dw = lead_dw[1:0];
      // 3dw header without pad needs D0 to finish its first beat
      wait_d0  = has_data && (shift_dw == 2'd3);
      cur_rem  = (state == tx_stream_pkg::st_payload) ? rem : desc_r.words;
      eop      = cur_rem <= tx_stream_pkg::dw_cnt_t'(4);

      if (state == tx_stream_pkg::st_idle) begin
         fire = hdr_go & ~wait_d0;
      end else begin
         // flush once the remaining dwords all sit in prev
         fire = take_r | (cur_rem <= tx_stream_pkg::dw_cnt_t'(shift_dw));
      end

      state_nx = state;
      if (fire) begin
         state_nx = eop ? tx_stream_pkg::st_idle : tx_stream_pkg::st_payload;
      end else if ((state == tx_stream_pkg::st_idle) && hdr_go) begin
         state_nx = tx_stream_pkg::st_header;
      end

      beat_nx.sop   = state != tx_stream_pkg::st_payload;
      beat_nx.err   = beat_nx.sop & desc_r.err;
      beat_nx.eop   = eop;
      beat_nx.empty = eop && (cur_rem <= tx_stream_pkg::dw_cnt_t'(2));
      if (state == tx_stream_pkg::st_idle) begin
         beat_nx.data = is_4dw ? desc_r.hdr : {desc_r.hdr[127:32], 32'h0};
      end else begin
         beat_nx.data = realign(prev_r, cur_r, shift_dw, cur_rem);
      end
   end

   always_ff @(posedge clk_in) begin
      if (!rstn) begin
         state <= tx_stream_pkg::st_idle;
         rem   <= '0;
         push  <= 1'b0;
      end else begin
         state <= state_nx;
         push  <= fire;
         if (fire) begin
            rem <= eop ? '0 : cur_rem - tx_stream_pkg::dw_cnt_t'(4);
         end
      end
   end

   always_ff @(posedge clk_in) begin
      if (fire) begin
         beat <= beat_nx;
      end
   end

endmodule

//--- source/tx_beat_fifo.sv
/*
 * Beat FIFO with a combinational read port. A beat pushed in one cycle is
 * readable the next. Pushes while full and pops while empty are ignored.
 */
`include "tx_stream_defs.svh"

module tx_beat_fifo (
   input  logic                     clk_in,
   input  logic                     rstn,
   input  logic                     push,
   input  tx_stream_pkg::tx_beat_t  wr_beat,
   input  logic                     pop,
   output tx_stream_pkg::tx_beat_t  rd_beat,
   output logic                     empty,
   output logic                     almost_full
);

   localparam int PTR_W = $clog2(`TXS_FIFO_DEPTH);
   localparam logic [PTR_W:0] FULL_CNT  = `TXS_FIFO_DEPTH;
   localparam logic [PTR_W:0] AFULL_CNT = `TXS_FIFO_DEPTH - `TXS_FIFO_AFULL_GAP;

   tx_stream_pkg::tx_beat_t  mem [`TXS_FIFO_DEPTH];
   logic [PTR_W-1:0]         wr_ptr;
   logic [PTR_W-1:0]         rd_ptr;
   logic [PTR_W:0]           count;
   logic                     full;
   logic                     wr_en;
   logic                     rd_en;

   assign full        = count == FULL_CNT;
   assign empty       = count == '0;
   assign almost_full = count >= AFULL_CNT;
   assign wr_en       = push & ~full;
   assign rd_en       = pop & ~empty;

   always_ff @(posedge clk_in) begin
      if (wr_en) begin
         mem[wr_ptr] <= wr_beat;
      end
   end

   // pointers wrap on their own since the depth is a power of two
   always_ff @(posedge clk_in) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count + {{PTR_W{1'b0}}, wr_en} - {{PTR_W{1'b0}}, rd_en};
      end
   end

   assign rd_beat = mem[rd_ptr];

endmodule

//--- source/tx_stream_out.sv
/*
 * Output side, ready latency one. A popped beat waits in a holding register
 * and is sent on the next cycle in which ready is high.
 */
module tx_stream_out (
   input  logic                     clk_in,
   input  logic                     rstn,
   input  logic                     tx_stream_ready,
   input  logic                     fifo_empty,
   input  tx_stream_pkg::tx_beat_t  rd_beat,
   output logic                     pop,
   output tx_stream_pkg::tx_beat_t  tx_stream_data,
   output logic                     tx_stream_valid
);

   tx_stream_pkg::tx_beat_t  hold_beat;
   logic                     hold_full;

   assign pop = tx_stream_ready & ~fifo_empty;

   // hold_full marks an unsent beat in hold_beat
   always_ff @(posedge clk_in) begin
      if (!rstn) begin
         hold_full       <= 1'b0;
         tx_stream_valid <= 1'b0;
      end else if (tx_stream_ready) begin
         hold_full       <= ~fifo_empty;
         tx_stream_valid <= hold_full;
      end else begin
         tx_stream_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk_in) begin
      if (pop) begin
         hold_beat <= rd_beat;
      end
      if (tx_stream_ready) begin
         tx_stream_data <= hold_beat;
      end
   end

endmodule

//--- source/tx_stream_top.sv
/*
 * 128-bit transmit stream builder: request control, beat packer,
 * beat FIFO and ready-latency-one output stage.
 */
`include "tx_stream_defs.svh"

module tx_stream_top (
   input  logic                     clk_in,
   input  logic                     rstn,
   input  logic                     tx_req,
   input  logic [`TXS_DATA_W-1:0]   tx_desc,
   input  logic                     tx_err,
   output logic                     tx_ack,
   output logic                     tx_ws,
   input  logic                     tx_dv,
   input  logic [`TXS_DATA_W-1:0]   tx_data,
   input  logic                     tx_stream_ready,
   output tx_stream_pkg::tx_beat_t  tx_stream_data,
   output logic                     tx_stream_valid,
   output logic                     tx_fifo_empty
);

   tx_stream_pkg::tx_desc_t  desc;
   tx_stream_pkg::tx_beat_t  wr_beat;
   tx_stream_pkg::tx_beat_t  rd_beat;
   logic                     desc_valid;
   logic                     data_take;
   logic                     push;
   logic                     pop;
   logic                     almost_full;

   tx_req_ctrl u_req_ctrl (
      .clk_in      (clk_in),
      .rstn        (rstn),
      .tx_req      (tx_req),
      .tx_desc     (tx_desc),
      .tx_err      (tx_err),
      .tx_dv       (tx_dv),
      .almost_full (almost_full),
      .tx_ack      (tx_ack),
      .tx_ws       (tx_ws),
      .desc        (desc),
      .desc_valid  (desc_valid),
      .data_take   (data_take)
   );

   tx_beat_packer u_packer (
      .clk_in      (clk_in),
      .rstn        (rstn),
      .desc        (desc),
      .desc_valid  (desc_valid),
      .data_take   (data_take),
      .tx_data     (tx_data),
      .push        (push),
      .beat        (wr_beat)
   );

   tx_beat_fifo u_fifo (
      .clk_in      (clk_in),
      .rstn        (rstn),
      .push        (push),
      .wr_beat     (wr_beat),
      .pop         (pop),
      .rd_beat     (rd_beat),
      .empty       (tx_fifo_empty),
      .almost_full (almost_full)
   );

   tx_stream_out u_out (
      .clk_in          (clk_in),
      .rstn            (rstn),
      .tx_stream_ready (tx_stream_ready),
      .fifo_empty      (tx_fifo_empty),
      .rd_beat         (rd_beat),
      .pop             (pop),
      .tx_stream_data  (tx_stream_data),
      .tx_stream_valid (tx_stream_valid)
   );

endmodule

//--- verif/tx_stream_tb.sv
/*
 * Testbench for the transmit stream builder. The engine model raises tx_req,
 * waits for tx_ack, then offers payload beats from the next cycle and holds
 * each one while tx_ws is high. Expected beats come from a reference model.
 */
`include "tx_stream_defs.svh"

module tx_stream_tb;

   timeunit 1ns;
   timeprecision 1ps;

   // upper bound on delivered beats over all tests, sets the watchdog
   localparam int MAX_BEATS       = 360;
   localparam int WATCHDOG_CYCLES = 40 * MAX_BEATS + 2000;
   localparam int READY_HIGH      = 0;
   localparam int READY_RANDOM    = 1;
   localparam int READY_LOW       = 2;

   logic                     clk_in;
   logic                     rstn;
   logic                     tx_req;
   logic [`TXS_DATA_W-1:0]   tx_desc;
   logic                     tx_err;
   logic                     tx_ack;
   logic                     tx_ws;
   logic                     tx_dv;
   logic [`TXS_DATA_W-1:0]   tx_data;
   logic                     tx_stream_ready;
   tx_stream_pkg::tx_beat_t  tx_stream_data;
   logic                     tx_stream_valid;
   logic                     tx_fifo_empty;

   tx_stream_pkg::tx_beat_t  exp_q [$];
   logic [`TXS_DATA_W-1:0]   payload [32];
   logic [31:0]              rnd_ready;
   logic                     ready_at_edge;
   integer                   seed;
   integer                   ready_seed;
   int                       ready_mode;
   int                       error_count;
   int                       test_start_errors;
   int                       tests_passed;
   int                       tests_failed;
   int                       beats_checked;
   string                    cur_test;

   tx_stream_top DUT (
      .clk_in          (clk_in),
      .rstn            (rstn),
      .tx_req          (tx_req),
      .tx_desc         (tx_desc),
      .tx_err          (tx_err),
      .tx_ack          (tx_ack),
      .tx_ws           (tx_ws),
      .tx_dv           (tx_dv),
      .tx_data         (tx_data),
      .tx_stream_ready (tx_stream_ready),
      .tx_stream_data  (tx_stream_data),
      .tx_stream_valid (tx_stream_valid),
      .tx_fifo_empty   (tx_fifo_empty)
   );

   initial begin
      clk_in = 1'b0;
   end

   always #5 clk_in = ~clk_in;

   // --------------------------------------------------------------------------
   // reference model: header, optional zero pad, payload, four dwords a beat
   // --------------------------------------------------------------------------
   function automatic void build_expected(input logic [`TXS_DATA_W-1:0] d,
                                          input logic e);
      logic [31:0]              dws [$];
      tx_stream_pkg::tx_beat_t  b;
      logic                     is_4dw;
      logic                     abit;
      logic                     pad;
      int                       len;
      int                       nbeats;
      is_4dw = d[`TXS_DESC_4DW_BIT];
      abit   = is_4dw ? d[`TXS_ADDR4_LSB+2] : d[`TXS_ADDR3_LSB+2];
      len    = d[`TXS_DESC_HASDATA_BIT] ? int'(d[`TXS_DESC_LEN_LSB +: `TXS_LEN_W]) : 0;
      pad    = (len != 0) && (is_4dw ? abit : !abit);
      for (int i = 0; i < (is_4dw ? 4 : 3); i++) begin
         dws.push_back(d[127-32*i -: 32]);
      end
      if (pad) begin
         dws.push_back(32'h0);
      end
      for (int k = 0; k < len; k++) begin
         dws.push_back(payload[k/4][32*(k%4) +: 32]);
      end
      nbeats = (dws.size() + 3) / 4;
      for (int i = 0; i < nbeats; i++) begin
         b = '0;
         for (int l = 0; l < 4; l++) begin
            if (4*i + l < dws.size()) begin
               b.data[127-32*l -: 32] = dws[4*i + l];
            end
         end
         b.sop   = (i == 0);
         b.err   = (i == 0) && e;
         b.eop   = (i == nbeats - 1);
         b.empty = b.eop && (dws.size() - 4*i <= 2);
         exp_q.push_back(b);
      end
   endfunction

   function automatic logic [`TXS_DATA_W-1:0] make_desc(input logic is_4dw,
      input logic has_data, input int len, input logic abit);
      logic [`TXS_DATA_W-1:0] d;
      d = {$random(seed), $random(seed), $random(seed), $random(seed)};
      d[`TXS_DESC_HASDATA_BIT] = has_data;
      d[`TXS_DESC_4DW_BIT]     = is_4dw;
      d[`TXS_DESC_LEN_LSB +: `TXS_LEN_W] = len[`TXS_LEN_W-1:0];
      if (is_4dw) begin
         d[`TXS_ADDR4_LSB+2] = abit;
      end else begin
         d[`TXS_ADDR3_LSB+2] = abit;
      end
      return d;
   endfunction

   // --------------------------------------------------------------------------
   // checks and test bookkeeping
   // --------------------------------------------------------------------------
   task automatic check_beat(input string what, input tx_stream_pkg::tx_beat_t exp,
                             input tx_stream_pkg::tx_beat_t act);
      if (act !== exp) begin
         error_count++;
         $display("ERROR %s: %s expected %h actual %h", cur_test, what, exp, act);
      end
   endtask

   task automatic check_flag(input string what, input logic exp, input logic act);
      if (act !== exp) begin
         error_count++;
         $display("ERROR %s: %s expected %b actual %b", cur_test, what, exp, act);
      end
   endtask

   task automatic begin_test(input string name);
      cur_test          = name;
      test_start_errors = error_count;
   endtask

   task automatic end_test();
      int errs;
      errs = error_count - test_start_errors;
      if (errs == 0) begin
         tests_passed++;
         $display("test %s: pass", cur_test);
      end else begin
         tests_failed++;
         $display("test %s: fail, %0d errors", cur_test, errs);
      end
   endtask

   // --------------------------------------------------------------------------
   // engine model
   // --------------------------------------------------------------------------
   task automatic send_packet(input logic [`TXS_DATA_W-1:0] d, input logic e);
      int len;
      int nbeats;
      int i;
      len    = d[`TXS_DESC_HASDATA_BIT] ? int'(d[`TXS_DESC_LEN_LSB +: `TXS_LEN_W]) : 0;
      nbeats = (len + 3) / 4;
      for (i = 0; i < nbeats; i++) begin
         payload[i] = {$random(seed), $random(seed), $random(seed), $random(seed)};
      end
      @(negedge clk_in);
      tx_req  = 1'b1;
      tx_desc = d;
      tx_err  = e;
      @(negedge clk_in);
      while (!tx_ack) begin
         @(negedge clk_in);
      end
      build_expected(d, e);
      @(negedge clk_in);
      tx_req = 1'b0;
      i = 0;
      // tx_ws is stable here until the next rising edge
      while (i < nbeats) begin
         tx_dv   = 1'b1;
         tx_data = payload[i];
         if (!tx_ws) begin
            i++;
         end
         @(negedge clk_in);
      end
      tx_dv = 1'b0;
   endtask

   task automatic send_random_packet();
      logic [31:0] rnd;
      rnd = $random(seed);
      send_packet(make_desc(rnd[0], 1'b1, 1 + int'(rnd[7:4]), rnd[1]), rnd[2]);
   endtask

   task automatic drain();
      while (exp_q.size() != 0) begin
         @(negedge clk_in);
      end
      repeat (4) @(negedge clk_in);
      check_flag("tx_fifo_empty after last beat", 1'b1, tx_fifo_empty);
      check_flag("tx_ws after last beat", 1'b0, tx_ws);
   endtask

   // sink ready pattern
   always @(negedge clk_in) begin
      case (ready_mode)
         READY_RANDOM: begin
            rnd_ready       = $random(ready_seed);
            tx_stream_ready = rnd_ready[1:0] != 2'b00;
         end
         READY_LOW: tx_stream_ready = 1'b0;
         default:   tx_stream_ready = 1'b1;
      endcase
   end

   always @(posedge clk_in) begin
      ready_at_edge <= tx_stream_ready;
   end

   // compare every delivered beat with the head of the expected queue
   always @(negedge clk_in) begin
      if (rstn && tx_stream_valid) begin
         if (!ready_at_edge) begin
            error_count++;
            $display("%s: a beat was sent without ready in the cycle before", cur_test);
         end
         if (exp_q.size() == 0) begin
            error_count++;
            $display("%s: a beat was delivered when none was expected", cur_test);
         end else begin
            check_beat("stream beat", exp_q.pop_front(), tx_stream_data);
         end
         beats_checked++;
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_in);
      $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Test FAILED");
      $finish;
   end

   // --------------------------------------------------------------------------
   // test sequence
   // --------------------------------------------------------------------------
   initial begin
      int wait_cycles;
      seed            = 32'ha254;
      ready_seed      = 32'ha254;
      rstn            = 1'b0;
      tx_req          = 1'b0;
      tx_desc         = '0;
      tx_err          = 1'b0;
      tx_dv           = 1'b0;
      tx_data         = '0;
      tx_stream_ready = 1'b1;
      ready_mode      = READY_HIGH;
      error_count     = 0;
      tests_passed    = 0;
      tests_failed    = 0;
      beats_checked   = 0;
      repeat (3) @(negedge clk_in);
      rstn = 1'b1;

      begin_test("reset");
      check_flag("tx_ack", 1'b0, tx_ack);
      check_flag("tx_ws", 1'b0, tx_ws);
      check_flag("tx_stream_valid", 1'b0, tx_stream_valid);
      check_flag("tx_fifo_empty", 1'b1, tx_fifo_empty);
      end_test();

      begin_test("dataless");
      for (int f = 0; f < 2; f++) begin
         for (int e = 0; e < 2; e++) begin
            send_packet(make_desc(f[0], 1'b0, 0, 1'b0), e[0]);
         end
      end
      drain();
      end_test();

      begin_test("length sweep");
      for (int f = 0; f < 2; f++) begin
         for (int a = 0; a < 2; a++) begin
            for (int len = 1; len <= 9; len++) begin
               send_packet(make_desc(f[0], 1'b1, len, a[0]), len[0]);
            end
         end
      end
      drain();
      end_test();

      begin_test("back to back");
      repeat (8) send_random_packet();
      drain();
      end_test();

      begin_test("random ready");
      ready_mode = READY_RANDOM;
      repeat (10) send_random_packet();
      drain();
      ready_mode = READY_HIGH;
      end_test();

      // 5 packets of 17 beats overfill the almost-full level
      begin_test("backpressure");
      ready_mode = READY_LOW;
      fork
         begin
            repeat (5) send_packet(make_desc(1'b1, 1'b1, 64, 1'b0), 1'b0);
         end
         begin
            wait_cycles = 0;
            while (!tx_ws && wait_cycles < 400) begin
               @(negedge clk_in);
               wait_cycles++;
            end
            if (!tx_ws) begin
               error_count++;
               $display("%s: tx_ws never rose while ready was held low", cur_test);
            end
            repeat (30) begin
               @(negedge clk_in);
               check_flag("tx_ws while stalled", 1'b1, tx_ws);
            end
            ready_mode = READY_HIGH;
         end
      join
      drain();
      end_test();

      $display("tests passed %0d, tests failed %0d, beats checked %0d, errors %0d",
               tests_passed, tests_failed, beats_checked, error_count);
      if (error_count == 0 && tests_failed == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

//--- src.f
+incdir+include
source/tx_stream_pkg.sv
source/tx_req_ctrl.sv
source/tx_beat_packer.sv
source/tx_beat_fifo.sv
source/tx_stream_out.sv
source/tx_stream_top.sv
verif/tx_stream_tb.sv

//--- Bender.yml
package:
  name: tx_stream

sources:
  - include_dirs:
      - include
    files:
      - source/tx_stream_pkg.sv
      - source/tx_req_ctrl.sv
      - source/tx_beat_packer.sv
      - source/tx_beat_fifo.sv
      - source/tx_stream_out.sv
      - source/tx_stream_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tx_stream_tb.sv
